//--- debug_link.f
+incdir+verilog
verilog/dbg_pkg.sv
verilog/snapshot_packer.sv
verilog/frame_sender.sv
verilog/uart_tx.sv
verilog/debug_link.sv
tb/debug_link_props.sv
tb/debug_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the debug link testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f debug_link.f --top-module debug_link_tb \
	-Mdir "$obj" -o debug_link_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj/debug_link_sim" +verilator+error+limit+1000 > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q -F '*** FAILED ***' "$log"; then
	echo "simulation reported failure, see $log"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
if ! grep -q -F '*** PASSED ***' "$log"; then
	echo "simulation ended without a result, see $log"
	exit 1
fi
exit 0

//--- tb/debug_link_props.sv
`include "dbg_defines.svh"

module debug_link_props (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            snap,
	input  logic            busy,
	input  logic            txd,
	input  logic            load,       // accepted snap, inside the dut
	input  dbg_pkg::frame_t frame       // held frame register
);

	localparam int BIT_CYC   = `DBG_CLKS_PER_BIT;
	localparam int BYTE_CYC  = 10 * BIT_CYC;                // start, 8 data, stop
	localparam int FRAME_CYC = `DBG_FRAME_BYTES * BYTE_CYC;

	int unsigned fail_cnt = 0;          // read by the testbench
	logic [15:0] snap_cyc;              // edges since accepted snap
	logic [15:0] line_pos;              // cycles into the serial frame
	logic        in_stop;               // line is inside a stop bit

	assign line_pos = snap_cyc - 16'd1; // start bit of byte 0 is one edge late
	assign in_stop  = busy && (snap_cyc != 16'd0)
		&& ((line_pos % 16'(BYTE_CYC)) >= 16'(BYTE_CYC - BIT_CYC));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			snap_cyc <= '0;
		else if (load)
			snap_cyc <= '0;             // restart at the accept edge
		else if (busy)
			snap_cyc <= snap_cyc + 16'd1;
	end

	//////////////////////////////////////////////////////////////////////
	// line levels
	//////////////////////////////////////////////////////////////////////

	reset_levels: assert property (@(posedge clk) !arst_n |-> (txd && !busy))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("txd low or busy high while in reset");
	end

	idle_high: assert property (@(posedge clk) disable iff (!arst_n) !busy |-> txd)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("txd low while the link is idle");
	end

	stop_bit: assert property (@(posedge clk) disable iff (!arst_n) in_stop |-> txd)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("stop bit sent as 0");
	end

	//////////////////////////////////////////////////////////////////////
	// snapshot timing
	//////////////////////////////////////////////////////////////////////

	// busy next edge, line still high for one more cycle
	snap_accept: assert property (@(posedge clk) disable iff (!arst_n)
		(snap && !busy) |=> (busy && txd))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("snap while idle did not raise busy one edge later");
	end

	start_bit: assert property (@(posedge clk) disable iff (!arst_n)
		$past(snap && !busy, 2) |-> !txd)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("start bit of byte 0 not two edges after snap");
	end

	frame_len: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(busy) |-> (snap_cyc == 16'(FRAME_CYC + 1)))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("busy fell at the wrong cycle for a full frame");
	end

	// a snap or state change mid frame leaves the frame alone
	frame_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(busy && $past(busy)) |-> $stable(frame))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("frame register changed while sending");
	end

	new_snap: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(busy) |-> $past(snap))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("frame started without a snap");
	end

endmodule

//--- tb/debug_link_tb.sv
`include "dbg_defines.svh"

module debug_link_tb;

	localparam int FRAME_CYC = `DBG_FRAME_BYTES * 10 * `DBG_CLKS_PER_BIT;
	localparam int LIMIT     = 3 * FRAME_CYC + 200;    // three frames plus slack
	localparam int PS_W      = $bits(dbg_pkg::pipe_state_t);

	logic                 clk;
	logic                 arst_n;
	logic                 snap;
	dbg_pkg::pipe_state_t pipe_state;
	logic                 txd;
	logic                 busy;

	integer     seed;
	int         cycles;
	int         byte_errs;                              // mismatching bytes
	int         rx_count;                               // bytes seen on txd
	int         put_idx;                                // fill point of exp_frame
	logic [7:0] exp_frame [`DBG_FRAME_BYTES];

	debug_link u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.snap       (snap),
		.pipe_state (pipe_state),
		.txd        (txd),
		.busy       (busy)
	);

	bind debug_link debug_link_props u_props (
		.clk    (clk),
		.arst_n (arst_n),
		.snap   (snap),
		.busy   (busy),
		.txd    (txd),
		.load   (load),
		.frame  (frame)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog
	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus and expected frame
	//////////////////////////////////////////////////////////////////////

	task automatic drive_random_state();
		logic [PS_W-1:0] raw;
		raw = '0;
		for (int i = 0; i < PS_W; i += 32)
			raw = {raw[PS_W-33:0], 32'($random(seed))};    // 32 fresh bits per pass
		pipe_state = raw;
	endtask

	task automatic put_byte(input logic [7:0] v);
		exp_frame[put_idx] = v;
		put_idx++;
	endtask

	// frame image straight from the byte layout rule
	task automatic build_expected(input dbg_pkg::pipe_state_t s);
		logic [31:0] pc32;
		put_idx = 0;
		pc32 = {23'd0, s.pc};
		for (int b = 0; b < 32; b += 8)
			put_byte(pc32[b +: 8]);
		for (int b = 0; b < 32; b += 8)
			put_byte(s.instr[b +: 8]);
		put_byte({6'd0, s.ctrl.mem_read});
		put_byte({7'd0, s.ctrl.reg_write});
		put_byte({7'd0, s.ctrl.mem_to_reg});
		put_byte({4'd0, s.ctrl.mem_write});
		put_byte({4'd0, s.ctrl.alu_ctrl});
		put_byte({6'd0, s.ctrl.alu_src});
		put_byte({7'd0, s.ctrl.reg_dst});
		put_byte({7'd0, s.ctrl.branch});
		for (int r = 0; r < `DBG_NUM_REGS; r++)
			for (int b = 0; b < 32; b += 8)
				put_byte(s.regs[r][b +: 8]);        // each word lsb first
		put_byte({7'd0, s.hazard.stall_f});
		put_byte({7'd0, s.hazard.stall_d});
		put_byte({6'd0, s.hazard.fwd_a_d});
		put_byte({6'd0, s.hazard.fwd_b_d});
		put_byte({7'd0, s.hazard.flush_e});
		put_byte({6'd0, s.hazard.fwd_a_e});
		put_byte({6'd0, s.hazard.fwd_b_e});
	endtask

	task automatic take_snapshot();
		@(negedge clk);
		drive_random_state();
		snap = 1'b1;                                      // one cycle strobe
		build_expected(pipe_state);
		@(negedge clk);
		snap = 1'b0;
	endtask

	// random snaps and state churn until the frame is out
	task automatic keep_busy_traffic();
		@(negedge clk);
		while (busy)
		begin
			drive_random_state();
			snap = (($random(seed) & 7) == 0);
			@(negedge clk);
		end
		snap = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy)
			@(negedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// serial receiver model
	//////////////////////////////////////////////////////////////////////

	task automatic receive_frame(input string name);
		logic [7:0] got;
		for (int i = 0; i < `DBG_FRAME_BYTES; i++)
		begin
			@(negedge clk);
			while (txd !== 1'b0)
				@(negedge clk);                           // hunt for start bit
			repeat (`DBG_CLKS_PER_BIT / 2) @(negedge clk); // middle of start bit
			for (int j = 0; j < 8; j++)
			begin
				repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
				got[j] = txd;                             // lsb arrives first
			end
			repeat (`DBG_CLKS_PER_BIT) @(negedge clk);   // middle of stop bit
			rx_count++;
			if (got !== exp_frame[i])
			begin
				byte_errs++;
				$display("FAILED %s byte %0d: expected %02h, actual %02h",
					name, i, exp_frame[i], got);
			end
		end
	endtask

	initial
	begin
		seed       = 32'hf560_0da5;
		arst_n     = 1'b0;
		snap       = 1'b0;
		pipe_state = '0;
		byte_errs  = 0;
		rx_count   = 0;
		put_idx    = 0;
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		repeat (5) @(negedge clk);

		take_snapshot();                                  // full frame under churn
		fork
			receive_frame("busy_frame");
			keep_busy_traffic();
		join
		wait_idle();
		repeat (20) @(negedge clk);                       // no snap, stays idle

		take_snapshot();                                  // cut short by reset
		repeat (300) @(negedge clk);
		arst_n = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		repeat (5) @(negedge clk);

		take_snapshot();
		receive_frame("after_reset");
		wait_idle();
		repeat (10) @(negedge clk);

		$display("summary: %0d bytes received, %0d byte mismatches, %0d assertion failures",
			rx_count, byte_errs, u_dut.u_props.fail_cnt);
		if (byte_errs == 0 && u_dut.u_props.fail_cnt == 0
			&& rx_count == 2 * `DBG_FRAME_BYTES)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verilog/dbg_defines.svh
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// debug link sizing
//////////////////////////////////////////////////////////////////////

// architectural registers dumped per frame
`define DBG_NUM_REGS 32

// pc word, instr word, 8 ctrl bytes, reg file, 7 hazard bytes
`define DBG_FRAME_BYTES (4 + 4 + 8 + 4 * `DBG_NUM_REGS + 7)

// serial bit time in clocks, short for simulation
`define DBG_CLKS_PER_BIT 4

// byte index width, must cover DBG_FRAME_BYTES
`define DBG_IDX_W 8

`endif

//--- verilog/dbg_pkg.sv
`include "dbg_defines.svh"

package dbg_pkg;

	//////////////////////////////////////////////////////////////////////
	// captured processor state
	//////////////////////////////////////////////////////////////////////

	// decode stage control lines
	typedef struct packed {
		logic [1:0] mem_read;   // load size / enable
		logic       reg_write;  // writeback enable
		logic       mem_to_reg; // wb mux select
		logic [3:0] mem_write;  // byte write strobes
		logic [3:0] alu_ctrl;   // alu op
		logic [1:0] alu_src;    // operand b select
		logic       reg_dst;    // rd vs rt
		logic       branch;     // branch in decode
	} dec_ctrl_t;

	// hazard unit outputs
	typedef struct packed {
		logic       stall_f;    // hold fetch
		logic       stall_d;    // hold decode
		logic       flush_e;    // bubble into execute
		logic [1:0] fwd_a_d;    // decode forward, operand a
		logic [1:0] fwd_b_d;    // decode forward, operand b
		logic [1:0] fwd_a_e;    // execute forward, operand a
		logic [1:0] fwd_b_e;    // execute forward, operand b
	} hazard_t;

	// everything sampled on one snapshot edge
	typedef struct packed {
		logic [8:0]                       pc;     // fetch pc
		logic [31:0]                      instr;  // decode instr
		dec_ctrl_t                        ctrl;
		logic [`DBG_NUM_REGS-1:0][31:0]   regs;   // reg file words
		hazard_t                          hazard;
	} pipe_state_t;

	// outgoing frame, element 0 goes out first
	typedef logic [`DBG_FRAME_BYTES-1:0][7:0] frame_t;

endpackage

//--- verilog/debug_link.sv
module debug_link (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 snap,       // host snapshot strobe
	input  dbg_pkg::pipe_state_t pipe_state,
	output logic                 txd,        // serial out
	output logic                 busy        // frame in flight
);

	logic            load;       // accepted snap
	dbg_pkg::frame_t frame;      // captured bytes
	logic            tx_valid;
	logic [7:0]      tx_byte;
	logic            tx_ready;

	snapshot_packer u_packer (
		.clk        (clk),
		.arst_n     (arst_n),
		.snap       (snap),
		.pipe_state (pipe_state),
		.busy       (busy),
		.load       (load),
		.frame      (frame)
	);

	frame_sender u_sender (
		.clk      (clk),
		.arst_n   (arst_n),
		.load     (load),
		.frame    (frame),
		.tx_ready (tx_ready),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte),
		.busy     (busy)
	);

	uart_tx u_uart (
		.clk      (clk),
		.arst_n   (arst_n),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte),
		.tx_ready (tx_ready),
		.txd      (txd)
	);

endmodule

//--- verilog/frame_sender.sv
`include "dbg_defines.svh"

module frame_sender (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            load,       // start a new frame
	input  dbg_pkg::frame_t frame,      // stable while busy
	input  logic            tx_ready,   // uart can take a byte
	output logic            tx_valid,
	output logic [7:0]      tx_byte,
	output logic            busy
);

	localparam int unsigned LAST_IDX = `DBG_FRAME_BYTES - 1;

	logic [`DBG_IDX_W-1:0] idx;         // byte being offered
	logic                  last_sent;   // final byte handed to uart
	logic                  xfer;        // byte accepted this cycle
	logic                  at_last;

	assign xfer    = tx_valid && tx_ready;
	assign at_last = (idx == LAST_IDX[`DBG_IDX_W-1:0]);
	assign tx_byte = frame[idx];        // mux of held frame regs

	//////////////////////////////////////////////////////////////////////
	// byte walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			idx       <= '0;
			tx_valid  <= 1'b0;
			busy      <= 1'b0;
			last_sent <= 1'b0;
		end
		else if (load)
		begin
			idx       <= '0;            // byte 0 offered next cycle
			tx_valid  <= 1'b1;
			busy      <= 1'b1;
			last_sent <= 1'b0;
		end
		else if (xfer)
		begin
			if (at_last)
			begin
				tx_valid  <= 1'b0;      // nothing more to offer
				last_sent <= 1'b1;
			end
			else
			begin
				idx <= idx + 1'b1;      // next byte, no gap
			end
		end
		else if (last_sent && tx_ready)
		begin
			// ready again means last stop bit ends this edge
			busy      <= 1'b0;
			last_sent <= 1'b0;
		end
	end

endmodule

//--- verilog/snapshot_packer.sv
`include "dbg_defines.svh"

module snapshot_packer (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                snap,        // one cycle host strobe
	input  dbg_pkg::pipe_state_t pipe_state,
	input  logic                busy,        // from sender
	output logic                load,
	output dbg_pkg::frame_t     frame
);

	localparam int CTRL_BASE = 8;                        // after pc + instr
	localparam int REG_BASE  = 16;                       // after ctrl bytes
	localparam int HAZ_BASE  = REG_BASE + 4 * `DBG_NUM_REGS;

	dbg_pkg::frame_t packed_frame;                       // next frame image
	logic [31:0]     pc_word;                            // zero extended pc

	assign load    = snap && !busy;                      // drop snaps mid frame
	assign pc_word = 32'(pipe_state.pc);

	//////////////////////////////////////////////////////////////////////
	// byte layout
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		packed_frame = '0;
		for (int b = 0; b < 4; b++)
		begin
			packed_frame[b]     = pc_word[8*b +: 8];          // lsb first
			packed_frame[4 + b] = pipe_state.instr[8*b +: 8];
		end

		// one byte per control field
		packed_frame[CTRL_BASE + 0] = 8'(pipe_state.ctrl.mem_read);
		packed_frame[CTRL_BASE + 1] = 8'(pipe_state.ctrl.reg_write);
		packed_frame[CTRL_BASE + 2] = 8'(pipe_state.ctrl.mem_to_reg);
		packed_frame[CTRL_BASE + 3] = 8'(pipe_state.ctrl.mem_write);
		packed_frame[CTRL_BASE + 4] = 8'(pipe_state.ctrl.alu_ctrl);
		packed_frame[CTRL_BASE + 5] = 8'(pipe_state.ctrl.alu_src);
		packed_frame[CTRL_BASE + 6] = 8'(pipe_state.ctrl.reg_dst);
		packed_frame[CTRL_BASE + 7] = 8'(pipe_state.ctrl.branch);

		for (int r = 0; r < `DBG_NUM_REGS; r++)
			for (int b = 0; b < 4; b++)
				packed_frame[REG_BASE + 4*r + b] = pipe_state.regs[r][8*b +: 8];

		// hazard bytes, wire order of the hazard unit
		packed_frame[HAZ_BASE + 0] = 8'(pipe_state.hazard.stall_f);
		packed_frame[HAZ_BASE + 1] = 8'(pipe_state.hazard.stall_d);
		packed_frame[HAZ_BASE + 2] = 8'(pipe_state.hazard.fwd_a_d);
		packed_frame[HAZ_BASE + 3] = 8'(pipe_state.hazard.fwd_b_d);
		packed_frame[HAZ_BASE + 4] = 8'(pipe_state.hazard.flush_e);
		packed_frame[HAZ_BASE + 5] = 8'(pipe_state.hazard.fwd_a_e);
		packed_frame[HAZ_BASE + 6] = 8'(pipe_state.hazard.fwd_b_e);
	end

	// frame only moves on an accepted snap, held while sending
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			frame <= '0;
		else if (load)
			frame <= packed_frame;
	end

endmodule

//--- verilog/uart_tx.sv
`include "dbg_defines.svh"

module uart_tx (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       tx_valid,
	input  logic [7:0] tx_byte,
	output logic       tx_ready,    // can take a byte next cycle
	output logic       txd          // 8N1, idles high
);

	localparam int               CYC_W    = $clog2(`DBG_CLKS_PER_BIT + 1);
	localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(`DBG_CLKS_PER_BIT - 1);
	localparam logic [3:0]       STOP_BIT = 4'd9;   // start, 8 data, stop

	logic             active;       // frame on the line
	logic [3:0]       bit_cnt;      // 0 start .. 9 stop
	logic [CYC_W-1:0] cyc_cnt;      // clocks into current bit
	logic [9:0]       shreg;        // {stop, data, start}
	logic             bit_end;
	logic             take;

	assign bit_end  = (cyc_cnt == CYC_LAST);
	assign tx_ready = !active || ((bit_cnt == STOP_BIT) && bit_end);
	assign take     = tx_valid && tx_ready;
	assign txd      = active ? shreg[0] : 1'b1;

	//////////////////////////////////////////////////////////////////////
	// bit timing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			active  <= 1'b0;
			bit_cnt <= '0;
			cyc_cnt <= '0;
		end
		else if (take)
		begin
			active  <= 1'b1;        // start bit next cycle
			bit_cnt <= '0;
			cyc_cnt <= '0;
		end
		else if (active)
		begin
			if (bit_end)
			begin
				cyc_cnt <= '0;
				if (bit_cnt == STOP_BIT)
					active <= 1'b0; // back to idle high
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
			else
			begin
				cyc_cnt <= cyc_cnt + 1'b1;
			end
		end
	end

	// data path, shifts right so lsb leaves first
	always_ff @(posedge clk)
	begin
		if (take)
			shreg <= {1'b1, tx_byte, 1'b0};
		else if (active && bit_end)
			shreg <= {1'b1, shreg[9:1]};
	end

endmodule
